/* hdl/issue_pkg.sv */
package issue_pkg;

  // Data path and PC width
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Link value points past the branch and its delay slot
  localparam logic [XLEN-1:0] LINK_OFFSET = 32'd8;

  // Unit class carried by each queue entry
  typedef enum logic [2:0] {
    class_alu    = 3'd0,
    class_muldiv = 3'd1,
    class_load   = 3'd2,
    class_store  = 3'd3,
    class_branch = 3'd4,
    class_jump   = 3'd5
  } inst_class_e;

  // Branch conditions, all but eq/ne compare A against zero
  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_eq     = 3'd1,
    cond_ne     = 3'd2,
    cond_gt     = 3'd3,
    cond_ge     = 3'd4,
    cond_lt     = 3'd5,
    cond_le     = 3'd6
  } branch_cond_e;

endpackage

/* hdl/operand_select.sv */
`timescale 1ns/1ps

module operand_select #(
  parameter int ISSUE_WIDTH = 4
) (
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_a_reg,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_b_reg,
  input  logic [ISSUE_WIDTH-1:0]                            iq_a_used,
  input  logic [ISSUE_WIDTH-1:0]                            iq_b_used,
  input  logic [ISSUE_WIDTH-1:0]                            rob_a_present,
  input  logic [ISSUE_WIDTH-1:0]                            rob_a_valid,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rob_a_value,
  input  logic [ISSUE_WIDTH-1:0]                            rob_b_present,
  input  logic [ISSUE_WIDTH-1:0]                            rob_b_valid,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rob_b_value,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rf_a_data,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rf_b_data,
  output logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] rf_a_addr,
  output logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] rf_b_addr,
  output logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       op_a,
  output logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       op_b,
  output logic [ISSUE_WIDTH-1:0]                            op_ready
);
  import issue_pkg::*;

  logic [ISSUE_WIDTH-1:0] a_avail;
  logic [ISSUE_WIDTH-1:0] b_avail;

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
    // Register file is read at the architectural source registers
    assign rf_a_addr[i] = iq_a_reg[i];
    assign rf_b_addr[i] = iq_b_reg[i];

    // A younger producer still in the ROB overrides the register file
    assign op_a[i] = rob_a_present[i] ? rob_a_value[i] : rf_a_data[i];
    assign op_b[i] = rob_b_present[i] ? rob_b_value[i] : rf_b_data[i];

    // Available when not in flight, or in flight with a finished result
    assign a_avail[i] = !rob_a_present[i] || rob_a_valid[i];
    assign b_avail[i] = !rob_b_present[i] || rob_b_valid[i];

    // Unused operands never hold an instruction back
    assign op_ready[i] = (a_avail[i] || !iq_a_used[i]) && (b_avail[i] || !iq_b_used[i]);
  end

endmodule

/* hdl/issue_select.sv */
`timescale 1ns/1ps

module issue_select #(
  parameter int ISSUE_WIDTH = 4,
  parameter int EX_UNITS    = 2
) (
  input  logic [ISSUE_WIDTH-1:0]                           iq_valid,
  input  issue_pkg::inst_class_e [ISSUE_WIDTH-1:0]         iq_class,
  input  logic [ISSUE_WIDTH-1:0]                           op_ready,
  input  logic                                             ls_ready,
  input  logic [EX_UNITS-1:0]                              ex_ready,
  input  logic                                             mul_ready,
  input  logic                                             branch_stall,
  output logic [ISSUE_WIDTH-1:0]                           iq_consumed,
  output logic                                             ls_load,
  output logic [$clog2(ISSUE_WIDTH)-1:0]                   ls_pick,
  output logic [EX_UNITS-1:0]                              ex_load,
  output logic [EX_UNITS-1:0][$clog2(ISSUE_WIDTH)-1:0]     ex_pick,
  output logic                                             mul_load,
  output logic [$clog2(ISSUE_WIDTH)-1:0]                   mul_pick,
  output logic                                             br_load,
  output logic [$clog2(ISSUE_WIDTH)-1:0]                   br_pick
);
  import issue_pkg::*;

  localparam int PICK_W = $clog2(ISSUE_WIDTH);

  always_comb begin
    logic stop;
    logic placed;

    stop        = 1'b0;
    placed      = 1'b0;
    iq_consumed = '0;
    ls_load     = 1'b0;
    ls_pick     = '0;
    ex_load     = '0;
    ex_pick     = '0;
    mul_load    = 1'b0;
    mul_pick    = '0;
    br_load     = 1'b0;
    br_pick     = '0;

    // Oldest slot first; the first slot that cannot go ends the scan
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      placed = 1'b0;
      if (!stop && iq_valid[i] && op_ready[i]) begin
        case (iq_class[i])
          class_branch, class_jump: begin
            if (!branch_stall && !br_load) begin
              br_load = 1'b1;
              br_pick = PICK_W'(i);
              placed  = 1'b1;
            end
          end
          class_load, class_store: begin
            if (ls_ready && !ls_load) begin
              ls_load = 1'b1;
              ls_pick = PICK_W'(i);
              placed  = 1'b1;
            end
          end
          class_muldiv: begin
            if (mul_ready && !mul_load) begin
              mul_load = 1'b1;
              mul_pick = PICK_W'(i);
              placed   = 1'b1;
            end
          end
          class_alu: begin
            // Lowest numbered free ALU wins
            for (int k = 0; k < EX_UNITS; k++) begin
              if (!placed && ex_ready[k] && !ex_load[k]) begin
                ex_load[k] = 1'b1;
                ex_pick[k] = PICK_W'(i);
                placed     = 1'b1;
              end
            end
            // Spill onto the mul unit when every ALU is taken
            if (!placed && mul_ready && !mul_load) begin
              mul_load = 1'b1;
              mul_pick = PICK_W'(i);
              placed   = 1'b1;
            end
          end
          default: placed = 1'b0;
        endcase
      end

      if (placed)
        iq_consumed[i] = 1'b1;
      else
        stop = 1'b1;
    end
  end

endmodule

/* hdl/dispatch_reg.sv */
`timescale 1ns/1ps

module dispatch_reg #(
  parameter int ISSUE_WIDTH = 4,
  parameter int ROB_SLOT_W  = 4
) (
  input  logic                                       clock,
  input  logic                                       reset_n,
  input  logic                                       load,
  input  logic [$clog2(ISSUE_WIDTH)-1:0]             pick,
  input  issue_pkg::inst_class_e [ISSUE_WIDTH-1:0]   iq_class,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0] op_a,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0] op_b,
  input  logic [ISSUE_WIDTH-1:0][ROB_SLOT_W-1:0]     iq_rob_slot,
  output logic                                       u_valid,
  output issue_pkg::inst_class_e                     u_class,
  output logic [issue_pkg::XLEN-1:0]                 u_a,
  output logic [issue_pkg::XLEN-1:0]                 u_b,
  output logic [ROB_SLOT_W-1:0]                      u_rob_slot
);
  import issue_pkg::*;

  // One cycle valid pulse per accepted instruction
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      u_valid <= 1'b0;
    else
      u_valid <= load;
  end

  // Payload only moves when this unit is chosen
  always_ff @(posedge clock) begin
    if (load) begin
      u_class    <= iq_class[pick];
      u_a        <= op_a[pick];
      u_b        <= op_b[pick];
      u_rob_slot <= iq_rob_slot[pick];
    end
  end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit #(
  parameter int ISSUE_WIDTH = 4,
  parameter int ROB_SLOT_W  = 4
) (
  input  logic                                              clock,
  input  logic                                              reset_n,
  input  logic                                              load,
  input  logic [$clog2(ISSUE_WIDTH)-1:0]                    pick,
  input  issue_pkg::branch_cond_e [ISSUE_WIDTH-1:0]         iq_cond,
  input  issue_pkg::inst_class_e [ISSUE_WIDTH-1:0]          iq_class,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       iq_pc,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       iq_target,
  input  logic [ISSUE_WIDTH-1:0]                            iq_rformat,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_dest_reg,
  input  logic [ISSUE_WIDTH-1:0]                            iq_dest_used,
  input  logic [ISSUE_WIDTH-1:0][ROB_SLOT_W-1:0]            iq_rob_slot,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       op_a,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       op_b,
  output logic [issue_pkg::XLEN-1:0]                        redirect_pc,
  output logic                                              redirect_valid,
  output logic                                              rob_wr_valid,
  output logic [ROB_SLOT_W-1:0]                             rob_wr_slot,
  output logic [issue_pkg::XLEN-1:0]                        rob_wr_link,
  output logic [issue_pkg::REG_ADDR_W-1:0]                  rob_wr_dest,
  output logic                                              rob_wr_dest_used
);
  import issue_pkg::*;

  logic              br_valid;
  branch_cond_e      br_cond;
  inst_class_e       br_class;
  logic [XLEN-1:0]   br_pc;
  logic [XLEN-1:0]   br_target;
  logic              br_rformat;
  logic [XLEN-1:0]   br_a;
  logic [XLEN-1:0]   br_b;
  logic              a_neg;
  logic              a_zero;
  logic              cond_ok;
  logic              taken;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      br_valid <= 1'b0;
    else
      br_valid <= load;
  end

  always_ff @(posedge clock) begin
    if (load) begin
      br_cond          <= iq_cond[pick];
      br_class         <= iq_class[pick];
      br_pc            <= iq_pc[pick];
      br_target        <= iq_target[pick];
      br_rformat       <= iq_rformat[pick];
      br_a             <= op_a[pick];
      br_b             <= op_b[pick];
      rob_wr_slot      <= iq_rob_slot[pick];
      rob_wr_dest      <= iq_dest_reg[pick];
      rob_wr_dest_used <= iq_dest_used[pick];
    end
  end

  // Sign and zero of A cover all the compare-with-zero conditions
  assign a_neg  = br_a[XLEN-1];
  assign a_zero = (br_a == '0);

  always_comb begin
    case (br_cond)
      cond_eq: cond_ok = (br_a == br_b);
      cond_ne: cond_ok = (br_a != br_b);
      cond_gt: cond_ok = !a_neg && !a_zero;
      cond_ge: cond_ok = !a_neg;
      cond_lt: cond_ok = a_neg;
      cond_le: cond_ok = a_neg || a_zero;
      default: cond_ok = 1'b1;
    endcase
  end

  assign taken          = (br_class == class_jump) || cond_ok;
  assign redirect_valid = br_valid && taken;
  // Register format jumps through A, the rest use the decoded target
  assign redirect_pc    = br_rformat ? br_a : br_target;

  assign rob_wr_valid   = br_valid;
  assign rob_wr_link    = br_pc + LINK_OFFSET;

endmodule

/* hdl/issue_top.sv */
`timescale 1ns/1ps

module issue_top #(
  parameter int ISSUE_WIDTH = 4,
  parameter int EX_UNITS    = 2,
  parameter int ROB_SLOT_W  = 4
) (
  input  logic                                              clock,
  input  logic                                              reset_n,
  // Instruction queue
  input  logic [ISSUE_WIDTH-1:0]                            iq_valid,
  input  issue_pkg::inst_class_e [ISSUE_WIDTH-1:0]          iq_class,
  input  issue_pkg::branch_cond_e [ISSUE_WIDTH-1:0]         iq_cond,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_a_reg,
  input  logic [ISSUE_WIDTH-1:0]                            iq_a_used,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_b_reg,
  input  logic [ISSUE_WIDTH-1:0]                            iq_b_used,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] iq_dest_reg,
  input  logic [ISSUE_WIDTH-1:0]                            iq_dest_used,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       iq_pc,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       iq_target,
  input  logic [ISSUE_WIDTH-1:0]                            iq_rformat,
  input  logic [ISSUE_WIDTH-1:0][ROB_SLOT_W-1:0]            iq_rob_slot,
  output logic [ISSUE_WIDTH-1:0]                            iq_consumed,
  // Register file read
  output logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] rf_a_addr,
  output logic [ISSUE_WIDTH-1:0][issue_pkg::REG_ADDR_W-1:0] rf_b_addr,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rf_a_data,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rf_b_data,
  // ROB lookup
  input  logic [ISSUE_WIDTH-1:0]                            rob_a_present,
  input  logic [ISSUE_WIDTH-1:0]                            rob_a_valid,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rob_a_value,
  input  logic [ISSUE_WIDTH-1:0]                            rob_b_present,
  input  logic [ISSUE_WIDTH-1:0]                            rob_b_valid,
  input  logic [ISSUE_WIDTH-1:0][issue_pkg::XLEN-1:0]       rob_b_value,
  // Load/store unit
  output logic                                              ls_valid,
  output issue_pkg::inst_class_e                            ls_class,
  output logic [issue_pkg::XLEN-1:0]                        ls_a,
  output logic [issue_pkg::XLEN-1:0]                        ls_b,
  output logic [ROB_SLOT_W-1:0]                             ls_rob_slot,
  input  logic                                              ls_ready,
  // ALU units
  output logic [EX_UNITS-1:0]                               ex_valid,
  output issue_pkg::inst_class_e [EX_UNITS-1:0]             ex_class,
  output logic [EX_UNITS-1:0][issue_pkg::XLEN-1:0]          ex_a,
  output logic [EX_UNITS-1:0][issue_pkg::XLEN-1:0]          ex_b,
  output logic [EX_UNITS-1:0][ROB_SLOT_W-1:0]               ex_rob_slot,
  input  logic [EX_UNITS-1:0]                               ex_ready,
  // Multiply/divide unit
  output logic                                              mul_valid,
  output issue_pkg::inst_class_e                            mul_class,
  output logic [issue_pkg::XLEN-1:0]                        mul_a,
  output logic [issue_pkg::XLEN-1:0]                        mul_b,
  output logic [ROB_SLOT_W-1:0]                             mul_rob_slot,
  input  logic                                              mul_ready,
  // Fetch redirect and ROB link write
  input  logic                                              branch_stall,
  output logic [issue_pkg::XLEN-1:0]                        redirect_pc,
  output logic                                              redirect_valid,
  output logic                                              rob_wr_valid,
  output logic [ROB_SLOT_W-1:0]                             rob_wr_slot,
  output logic [issue_pkg::XLEN-1:0]                        rob_wr_link,
  output logic [issue_pkg::REG_ADDR_W-1:0]                  rob_wr_dest,
  output logic                                              rob_wr_dest_used
);
  import issue_pkg::*;

  localparam int PICK_W = $clog2(ISSUE_WIDTH);

  logic [ISSUE_WIDTH-1:0][XLEN-1:0] op_a;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0] op_b;
  logic [ISSUE_WIDTH-1:0]           op_ready;
  logic                             ls_load;
  logic [PICK_W-1:0]                ls_pick;
  logic [EX_UNITS-1:0]              ex_load;
  logic [EX_UNITS-1:0][PICK_W-1:0]  ex_pick;
  logic                             mul_load;
  logic [PICK_W-1:0]                mul_pick;
  logic                             br_load;
  logic [PICK_W-1:0]                br_pick;

  operand_select #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_operand_select (
    .iq_a_reg, .iq_b_reg, .iq_a_used, .iq_b_used,
    .rob_a_present, .rob_a_valid, .rob_a_value,
    .rob_b_present, .rob_b_valid, .rob_b_value,
    .rf_a_data, .rf_b_data, .rf_a_addr, .rf_b_addr,
    .op_a, .op_b, .op_ready
  );

  issue_select #(.ISSUE_WIDTH(ISSUE_WIDTH), .EX_UNITS(EX_UNITS)) u_issue_select (
    .iq_valid, .iq_class, .op_ready,
    .ls_ready, .ex_ready, .mul_ready, .branch_stall,
    .iq_consumed,
    .ls_load, .ls_pick, .ex_load, .ex_pick,
    .mul_load, .mul_pick, .br_load, .br_pick
  );

  dispatch_reg #(.ISSUE_WIDTH(ISSUE_WIDTH), .ROB_SLOT_W(ROB_SLOT_W)) u_ls_reg (
    .clock, .reset_n, .load(ls_load), .pick(ls_pick),
    .iq_class, .op_a, .op_b, .iq_rob_slot,
    .u_valid(ls_valid), .u_class(ls_class), .u_a(ls_a), .u_b(ls_b),
    .u_rob_slot(ls_rob_slot)
  );

  for (genvar k = 0; k < EX_UNITS; k++) begin : g_ex
    dispatch_reg #(.ISSUE_WIDTH(ISSUE_WIDTH), .ROB_SLOT_W(ROB_SLOT_W)) u_ex_reg (
      .clock, .reset_n, .load(ex_load[k]), .pick(ex_pick[k]),
      .iq_class, .op_a, .op_b, .iq_rob_slot,
      .u_valid(ex_valid[k]), .u_class(ex_class[k]), .u_a(ex_a[k]), .u_b(ex_b[k]),
      .u_rob_slot(ex_rob_slot[k])
    );
  end

  dispatch_reg #(.ISSUE_WIDTH(ISSUE_WIDTH), .ROB_SLOT_W(ROB_SLOT_W)) u_mul_reg (
    .clock, .reset_n, .load(mul_load), .pick(mul_pick),
    .iq_class, .op_a, .op_b, .iq_rob_slot,
    .u_valid(mul_valid), .u_class(mul_class), .u_a(mul_a), .u_b(mul_b),
    .u_rob_slot(mul_rob_slot)
  );

  branch_unit #(.ISSUE_WIDTH(ISSUE_WIDTH), .ROB_SLOT_W(ROB_SLOT_W)) u_branch_unit (
    .clock, .reset_n, .load(br_load), .pick(br_pick),
    .iq_cond, .iq_class, .iq_pc, .iq_target, .iq_rformat,
    .iq_dest_reg, .iq_dest_used, .iq_rob_slot, .op_a, .op_b,
    .redirect_pc, .redirect_valid,
    .rob_wr_valid, .rob_wr_slot, .rob_wr_link, .rob_wr_dest, .rob_wr_dest_used
  );

endmodule

/* bench/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb;
  import issue_pkg::*;

  localparam int ISSUE_WIDTH   = 4;
  localparam int EX_UNITS      = 2;
  localparam int ROB_SLOT_W    = 4;
  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 6;
  localparam int SWEEP_CYCLES  = 42;
  localparam int RANDOM_CYCLES = 400;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + SWEEP_CYCLES + RANDOM_CYCLES + 2;
  localparam int TIMEOUT_NS    = TOTAL_CYCLES * CLK_PERIOD + 400;
  localparam logic [31:0] LFSR_SEED = 32'h2b87;

  // Unit numbering used by the reference model
  localparam int LS_UNIT  = 0;
  localparam int MUL_UNIT = EX_UNITS + 1;
  localparam int BR_UNIT  = EX_UNITS + 2;
  localparam int N_UNITS  = EX_UNITS + 2;

  typedef struct packed {
    logic                  valid;
    logic [2:0]            cls;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [ROB_SLOT_W-1:0] slot;
  } unit_exp_t;

  typedef struct packed {
    logic [ISSUE_WIDTH-1:0]  consumed;
    unit_exp_t [N_UNITS-1:0] unit;
    logic                    br_valid;
    logic                    br_taken;
    logic [31:0]             br_pc_out;
    logic [31:0]             link;
    logic [ROB_SLOT_W-1:0]   br_slot;
    logic [REG_ADDR_W-1:0]   dest;
    logic                    dest_used;
  } exp_t;

  logic clock;
  logic reset_n;
  logic [ISSUE_WIDTH-1:0]                  iq_valid;
  inst_class_e [ISSUE_WIDTH-1:0]           iq_class;
  branch_cond_e [ISSUE_WIDTH-1:0]          iq_cond;
  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]  iq_a_reg;
  logic [ISSUE_WIDTH-1:0]                  iq_a_used;
  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]  iq_b_reg;
  logic [ISSUE_WIDTH-1:0]                  iq_b_used;
  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]  iq_dest_reg;
  logic [ISSUE_WIDTH-1:0]                  iq_dest_used;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        iq_pc;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        iq_target;
  logic [ISSUE_WIDTH-1:0]                  iq_rformat;
  logic [ISSUE_WIDTH-1:0][ROB_SLOT_W-1:0]  iq_rob_slot;
  logic [ISSUE_WIDTH-1:0]                  iq_consumed;
  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]  rf_a_addr;
  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]  rf_b_addr;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        rf_a_data;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        rf_b_data;
  logic [ISSUE_WIDTH-1:0]                  rob_a_present;
  logic [ISSUE_WIDTH-1:0]                  rob_a_valid;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        rob_a_value;
  logic [ISSUE_WIDTH-1:0]                  rob_b_present;
  logic [ISSUE_WIDTH-1:0]                  rob_b_valid;
  logic [ISSUE_WIDTH-1:0][XLEN-1:0]        rob_b_value;
  logic                                    ls_valid;
  inst_class_e                             ls_class;
  logic [XLEN-1:0]                         ls_a;
  logic [XLEN-1:0]                         ls_b;
  logic [ROB_SLOT_W-1:0]                   ls_rob_slot;
  logic                                    ls_ready;
  logic [EX_UNITS-1:0]                     ex_valid;
  inst_class_e [EX_UNITS-1:0]              ex_class;
  logic [EX_UNITS-1:0][XLEN-1:0]           ex_a;
  logic [EX_UNITS-1:0][XLEN-1:0]           ex_b;
  logic [EX_UNITS-1:0][ROB_SLOT_W-1:0]     ex_rob_slot;
  logic [EX_UNITS-1:0]                     ex_ready;
  logic                                    mul_valid;
  inst_class_e                             mul_class;
  logic [XLEN-1:0]                         mul_a;
  logic [XLEN-1:0]                         mul_b;
  logic [ROB_SLOT_W-1:0]                   mul_rob_slot;
  logic                                    mul_ready;
  logic                                    branch_stall;
  logic [XLEN-1:0]                         redirect_pc;
  logic                                    redirect_valid;
  logic                                    rob_wr_valid;
  logic [ROB_SLOT_W-1:0]                   rob_wr_slot;
  logic [XLEN-1:0]                         rob_wr_link;
  logic [REG_ADDR_W-1:0]                   rob_wr_dest;
  logic                                    rob_wr_dest_used;

  // Register file and ROB contents per architectural register
  logic [XLEN-1:0] rf_mem       [32];
  logic            rob_pres_mem [32];
  logic            rob_val_mem  [32];
  logic [XLEN-1:0] rob_data_mem [32];

  logic [31:0] lfsr_state;
  string       test_name;
  exp_t        exp_q[$];

  issue_top dut0 (.*);

  initial begin : clock_gen
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Both lookups answer in the same cycle
  always_comb begin
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      rf_a_data[i]     = rf_mem[rf_a_addr[i]];
      rf_b_data[i]     = rf_mem[rf_b_addr[i]];
      rob_a_present[i] = rob_pres_mem[iq_a_reg[i]];
      rob_a_valid[i]   = rob_val_mem[iq_a_reg[i]];
      rob_a_value[i]   = rob_data_mem[iq_a_reg[i]];
      rob_b_present[i] = rob_pres_mem[iq_b_reg[i]];
      rob_b_valid[i]   = rob_val_mem[iq_b_reg[i]];
      rob_b_value[i]   = rob_data_mem[iq_b_reg[i]];
    end
  end

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int n = 0; n < nbits; n++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic operand_ok(input logic used, input logic [REG_ADDR_W-1:0] r);
    return !used || !rob_pres_mem[r] || rob_val_mem[r];
  endfunction

  function automatic logic [31:0] operand_value(input logic [REG_ADDR_W-1:0] r);
    return rob_pres_mem[r] ? rob_data_mem[r] : rf_mem[r];
  endfunction

  function automatic logic cond_holds(input branch_cond_e c, input logic [31:0] a,
                                      input logic [31:0] b);
    case (c)
      cond_eq: return a == b;
      cond_ne: return a != b;
      cond_gt: return $signed(a) > 0;
      cond_ge: return $signed(a) >= 0;
      cond_lt: return $signed(a) < 0;
      cond_le: return $signed(a) <= 0;
      default: return 1'b1;
    endcase
  endfunction

  // Unit that takes this class given the free units or -1 when none fits
  function automatic int unit_for(input inst_class_e cls, input logic [BR_UNIT:0] free);
    case (cls)
      class_branch, class_jump: return free[BR_UNIT] ? BR_UNIT : -1;
      class_load, class_store:  return free[LS_UNIT] ? LS_UNIT : -1;
      class_muldiv:             return free[MUL_UNIT] ? MUL_UNIT : -1;
      class_alu: begin
        for (int k = 1; k <= EX_UNITS; k++)
          if (free[k]) return k;
        return free[MUL_UNIT] ? MUL_UNIT : -1;
      end
      default: return -1;
    endcase
  endfunction

  function automatic exp_t predict_issue();
    exp_t            e;
    unit_exp_t       u;
    logic [BR_UNIT:0] free;
    logic [31:0]     a_v;
    logic [31:0]     b_v;
    logic            stop;
    int              target;
    e = '0;
    stop = 1'b0;
    free[LS_UNIT] = ls_ready;
    for (int k = 0; k < EX_UNITS; k++)
      free[k + 1] = ex_ready[k];
    free[MUL_UNIT] = mul_ready;
    free[BR_UNIT]  = !branch_stall;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      a_v = operand_value(iq_a_reg[i]);
      b_v = operand_value(iq_b_reg[i]);
      target = -1;
      if (!stop && iq_valid[i] && operand_ok(iq_a_used[i], iq_a_reg[i])
          && operand_ok(iq_b_used[i], iq_b_reg[i]))
        target = unit_for(iq_class[i], free);
      if (target < 0) begin
        stop = 1'b1;
      end else begin
        e.consumed[i] = 1'b1;
        free[target]  = 1'b0;
        if (target == BR_UNIT) begin
          e.br_valid  = 1'b1;
          e.br_taken  = (iq_class[i] == class_jump) || cond_holds(iq_cond[i], a_v, b_v);
          e.br_pc_out = iq_rformat[i] ? a_v : iq_target[i];
          e.link      = iq_pc[i] + 32'd8;
          e.br_slot   = iq_rob_slot[i];
          e.dest      = iq_dest_reg[i];
          e.dest_used = iq_dest_used[i];
        end else begin
          u.valid = 1'b1;
          u.cls   = iq_class[i];
          u.a     = a_v;
          u.b     = b_v;
          u.slot  = iq_rob_slot[i];
          e.unit[target] = u;
        end
      end
    end
    return e;
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_unit(input string name, input unit_exp_t e, input logic v,
                            input logic [2:0] cls, input logic [31:0] a,
                            input logic [31:0] b, input logic [ROB_SLOT_W-1:0] slot);
    check_value({name, "_valid"}, 32'(e.valid), 32'(v));
    if (e.valid) begin
      check_value({name, "_class"}, 32'(e.cls), 32'(cls));
      check_value({name, "_a"}, e.a, a);
      check_value({name, "_b"}, e.b, b);
      check_value({name, "_rob_slot"}, 32'(e.slot), 32'(slot));
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #(DRIVE_DELAY);
  endtask

  task automatic randomize_readies();
    ls_ready = (rand_bits(2) != 0);
    for (int k = 0; k < EX_UNITS; k++)
      ex_ready[k] = (rand_bits(2) != 0);
    mul_ready    = (rand_bits(2) != 0);
    branch_stall = (rand_bits(2) == 0);
  endtask

  task automatic drive_idle();
    iq_valid = '0;
    randomize_readies();
  endtask

  task automatic drive_random();
    int nvalid;
    nvalid = int'(rand_bits(3) % 5);
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      iq_valid[i]     = (i < nvalid);
      iq_class[i]     = inst_class_e'(3'(rand_bits(3) % 6));
      iq_cond[i]      = branch_cond_e'(3'(rand_bits(3) % 7));
      iq_a_reg[i]     = 5'(rand_bits(5));
      iq_b_reg[i]     = 5'(rand_bits(5));
      iq_a_used[i]    = 1'(rand_bits(1));
      iq_b_used[i]    = 1'(rand_bits(1));
      iq_dest_reg[i]  = 5'(rand_bits(5));
      iq_dest_used[i] = 1'(rand_bits(1));
      iq_pc[i]        = rand_bits(32);
      iq_target[i]    = rand_bits(32);
      iq_rformat[i]   = 1'(rand_bits(1));
      iq_rob_slot[i]  = 4'(rand_bits(4));
    end
    for (int r = 0; r < 32; r++) begin
      rob_pres_mem[r] = 1'(rand_bits(1));
      rob_val_mem[r]  = (rand_bits(2) != 0);
      rob_data_mem[r] = rand_bits(32);
    end
    randomize_readies();
  endtask

  // One branch in slot 0 with operands from the register file
  task automatic drive_branch(input branch_cond_e c, input logic [31:0] a,
                              input logic [31:0] b, input logic rformat);
    iq_valid        = 4'b0001;
    iq_class[0]     = class_branch;
    iq_cond[0]      = c;
    iq_a_reg[0]     = 5'd1;
    iq_b_reg[0]     = 5'd2;
    iq_a_used[0]    = 1'b1;
    iq_b_used[0]    = 1'b1;
    iq_dest_reg[0]  = 5'(rand_bits(5));
    iq_dest_used[0] = 1'(rand_bits(1));
    iq_pc[0]        = rand_bits(32);
    iq_target[0]    = rand_bits(32);
    iq_rformat[0]   = rformat;
    iq_rob_slot[0]  = 4'(rand_bits(4));
    rf_mem[1]       = a;
    rf_mem[2]       = b;
    rob_pres_mem[1] = 1'b0;
    rob_pres_mem[2] = 1'b0;
    ls_ready        = 1'b1;
    ex_ready        = '1;
    mul_ready       = 1'b1;
    branch_stall    = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] a;
    lfsr_state = LFSR_SEED;
    test_name  = "reset";
    reset_n    = 1'b0;
    drive_random();
    drive_idle();
    for (int r = 0; r < 32; r++)
      rf_mem[r] = rand_bits(32);
    repeat (RESET_CYCLES) @(posedge clock);
    #(DRIVE_DELAY);
    reset_n = 1'b1;

    test_name = "idle";
    repeat (IDLE_CYCLES) begin
      next_cycle();
      drive_idle();
      exp_q.push_back(predict_issue());
    end

    // Every condition against negative, zero and positive A
    test_name = "branch_sweep";
    for (int c = 0; c < 7; c++) begin
      for (int sgn = 0; sgn < 3; sgn++) begin
        for (int rf = 0; rf < 2; rf++) begin
          a = (sgn == 0) ? 32'hffff_fff9 : ((sgn == 1) ? 32'd0 : 32'd13);
          next_cycle();
          drive_branch(branch_cond_e'(3'(c)), a, (rf == 1) ? a : a + 32'd1, 1'(rf));
          exp_q.push_back(predict_issue());
        end
      end
    end

    test_name = "random";
    repeat (RANDOM_CYCLES) begin
      next_cycle();
      drive_random();
      exp_q.push_back(predict_issue());
    end

    // One idle cycle so the last issue reaches the unit outputs
    test_name = "drain";
    next_cycle();
    drive_idle();
    exp_q.push_back(predict_issue());
    @(negedge clock);
    #1;
    $display("Done: no errors");
    $finish;
  end

  // Consumed mask is checked this cycle and unit outputs one cycle later
  initial begin : compare_outputs
    exp_t cur;
    exp_t prev;
    prev = '0;
    // Reset clears the consumed mask and every valid output
    @(negedge clock);
    check_value("iq_consumed", 32'd0, 32'(iq_consumed));
    check_value("ls_valid", 32'd0, 32'(ls_valid));
    check_value("ex_valid", 32'd0, 32'(ex_valid));
    check_value("mul_valid", 32'd0, 32'(mul_valid));
    check_value("redirect_valid", 32'd0, 32'(redirect_valid));
    check_value("rob_wr_valid", 32'd0, 32'(rob_wr_valid));
    @(posedge reset_n);
    forever begin
      @(negedge clock);
      if (exp_q.size() > 0) begin
        cur = exp_q.pop_front();
        check_value("iq_consumed", 32'(cur.consumed), 32'(iq_consumed));
        check_unit("ls", prev.unit[LS_UNIT], ls_valid, ls_class, ls_a, ls_b, ls_rob_slot);
        for (int k = 0; k < EX_UNITS; k++)
          check_unit($sformatf("ex%0d", k), prev.unit[k + 1], ex_valid[k], ex_class[k],
                     ex_a[k], ex_b[k], ex_rob_slot[k]);
        check_unit("mul", prev.unit[MUL_UNIT], mul_valid, mul_class, mul_a, mul_b,
                   mul_rob_slot);
        check_value("rob_wr_valid", 32'(prev.br_valid), 32'(rob_wr_valid));
        check_value("redirect_valid", 32'(prev.br_valid && prev.br_taken),
                    32'(redirect_valid));
        if (prev.br_valid) begin
          if (prev.br_taken)
            check_value("redirect_pc", prev.br_pc_out, redirect_pc);
          check_value("rob_wr_slot", 32'(prev.br_slot), 32'(rob_wr_slot));
          check_value("rob_wr_link", prev.link, rob_wr_link);
          check_value("rob_wr_dest", 32'(prev.dest), 32'(rob_wr_dest));
          check_value("rob_wr_dest_used", 32'(prev.dest_used), 32'(rob_wr_dest_used));
        end
        prev = cur;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    stop_with_failure();
  end

endmodule

/* sources.f */
hdl/issue_pkg.sv
hdl/operand_select.sv
hdl/issue_select.sv
hdl/dispatch_reg.sv
hdl/branch_unit.sv
hdl/issue_top.sv
bench/issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
